// File: hw/csr_pkg.sv
/*
 Shared definitions for the machine-mode CSR unit.
 Only machine mode is modelled; mtvec is direct mode only.
 Interrupt bits follow the standard mie/mip layout: external 11, timer 7,
 software 3. The software bit carries the environment call here.
*/
package csr_pkg;

	// Machine trap setup and handling.
	localparam logic [11:0] csr_mstatus = 12'h300;
	localparam logic [11:0] csr_mie = 12'h304;
	localparam logic [11:0] csr_mtvec = 12'h305;
	localparam logic [11:0] csr_mscratch = 12'h340;
	localparam logic [11:0] csr_mepc = 12'h341;
	localparam logic [11:0] csr_mcause = 12'h342;
	localparam logic [11:0] csr_mip = 12'h344;

	// Read-only counters, low and high halves.
	localparam logic [11:0] csr_cycle = 12'hc00;
	localparam logic [11:0] csr_time = 12'hc01;
	localparam logic [11:0] csr_instret = 12'hc02;
	localparam logic [11:0] csr_cycleh = 12'hc80;
	localparam logic [11:0] csr_timeh = 12'hc81;
	localparam logic [11:0] csr_instreth = 12'hc82;

	// Machine identity.
	localparam logic [11:0] csr_mvendorid = 12'hf11;
	localparam logic [11:0] csr_marchid = 12'hf12;
	localparam logic [11:0] csr_mimpid = 12'hf13;
	localparam logic [11:0] csr_mhartid = 12'hf14;

	// Bit 31 flags an interrupt, the rest is the cause code.
	localparam logic [31:0] cause_external = 32'h8000_000b;
	localparam logic [31:0] cause_timer = 32'h8000_0007;
	localparam logic [31:0] cause_ecall = 32'h0000_000b;

	localparam int unsigned mstatus_mie_bit = 3;
	localparam int unsigned mstatus_mpie_bit = 7;

	typedef struct packed {
		logic [19:0] reserved_31_12;
		logic external;
		logic [2:0] reserved_10_8;
		logic timer;
		logic [2:0] reserved_6_4;
		logic software;
		logic [2:0] reserved_2_0;
	} irq_bits_t;

	typedef union packed {
		logic [31:0] raw;
		irq_bits_t bits;
	} irq_word_u;

	typedef struct packed {
		logic [11:0] index;
		logic [31:0] wdata;
		logic write;
	} csr_req_t;

	typedef struct packed {
		logic mstatus_we;
		logic mip_we;
		logic [31:0] wdata;
	} csr_write_t;

	typedef struct packed {
		logic [31:0] mstatus;
		logic [31:0] mip;
		logic [31:0] mcause;
	} trap_state_t;

	typedef struct packed {
		logic pending;
		logic [31:0] pc;
	} irq_request_t;

	typedef struct packed {
		logic dispatched;
		logic [31:0] epc;
	} irq_dispatch_t;

	typedef struct packed {
		logic [63:0] cycle;
		logic [63:0] wtime;
		logic [63:0] instret;
	} counters_t;

	// Keep only the three defined interrupt bits of a written word.
	function automatic irq_bits_t irq_filter(input irq_word_u word);
		irq_bits_t result;
		result = '0;
		result.external = word.bits.external;
		result.timer = word.bits.timer;
		result.software = word.bits.software;
		return result;
	endfunction

endpackage

// File: hw/csr_file.sv
/*
 Software-visible machine CSRs and the read multiplexer.
 Reads are combinational; writes land on the rising edge.
 mstatus and mip live in the trap controller; this block only decodes
 their write strobes. A dispatch pulse overrides a software write to mepc
 in the same cycle. Unknown indexes read as zero and ignore writes.
*/
`timescale 1ns/10ps

module csr_file import csr_pkg::*; #(
	parameter logic [31:0] VENDORID = 32'd0,
	parameter logic [31:0] ARCHID = 32'd0,
	parameter logic [31:0] IMPID = 32'd0,
	parameter logic [31:0] HARTID = 32'd0
)(
	input logic i_clock,
	input logic i_reset,

	// Software access from the pipeline.
	input csr_req_t i_csr,
	output logic [31:0] o_rdata,

	// Trap entry and state owned elsewhere.
	input irq_dispatch_t i_dispatch,
	input trap_state_t i_trap,
	input counters_t i_counters,

	// Towards the trap controller.
	output csr_write_t o_write,
	output irq_bits_t o_enables,
	output logic [31:0] o_mtvec,

	// Direct reads.
	output logic [31:0] o_epc,
	output logic [31:0] o_scratch,
	output logic o_external_interrupt_enable
);
	logic [31:0] mtvec;
	logic [31:0] mscratch;
	logic [31:0] mepc;
	irq_bits_t mie;

	// Write data and mie seen both as raw words and as interrupt fields.
	irq_word_u wr_word;
	irq_word_u mie_word;

	always_comb begin
		wr_word.raw = i_csr.wdata;
		mie_word.bits = mie;
	end

	// Strobes for the registers held by the trap controller.
	always_comb begin
		o_write.mstatus_we = i_csr.write && (i_csr.index == csr_mstatus);
		o_write.mip_we = i_csr.write && (i_csr.index == csr_mip);
		o_write.wdata = i_csr.wdata;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mtvec <= '0;
			mscratch <= '0;
			mepc <= '0;
			mie <= '0;
			mie.external <= 1'b1;
			mie.timer <= 1'b1;
			mie.software <= 1'b1;
		end
		else begin
			if (i_csr.write) begin
				case (i_csr.index)
					csr_mie: mie <= irq_filter(wr_word);
					csr_mtvec: mtvec <= i_csr.wdata;
					csr_mscratch: mscratch <= i_csr.wdata;
					csr_mepc: mepc <= i_csr.wdata;
					default: ;
				endcase
			end

			// Return address handed over by the pipeline on trap entry.
			if (i_dispatch.dispatched) begin
				mepc <= i_dispatch.epc;
			end
		end
	end

	// Read by index; counters are split into halves.
	always_comb begin
		case (i_csr.index)
			csr_mstatus: o_rdata = i_trap.mstatus;
			csr_mie: o_rdata = mie_word.raw;
			csr_mtvec: o_rdata = mtvec;
			csr_mscratch: o_rdata = mscratch;
			csr_mepc: o_rdata = mepc;
			csr_mcause: o_rdata = i_trap.mcause;
			csr_mip: o_rdata = i_trap.mip;
			csr_cycle: o_rdata = i_counters.cycle[31:0];
			csr_cycleh: o_rdata = i_counters.cycle[63:32];
			csr_time: o_rdata = i_counters.wtime[31:0];
			csr_timeh: o_rdata = i_counters.wtime[63:32];
			csr_instret: o_rdata = i_counters.instret[31:0];
			csr_instreth: o_rdata = i_counters.instret[63:32];
			csr_mvendorid: o_rdata = VENDORID;
			csr_marchid: o_rdata = ARCHID;
			csr_mimpid: o_rdata = IMPID;
			csr_mhartid: o_rdata = HARTID;
			default: o_rdata = '0;
		endcase
	end

	assign o_enables = mie;
	assign o_mtvec = mtvec;
	assign o_epc = mepc;
	assign o_scratch = mscratch;

	// Gates the external interrupt source outside the core.
	assign o_external_interrupt_enable = mie.external;

endmodule

// File: hw/trap_controller.sv
/*
 Interrupt latching, priority issue and the trap handshake.
 Priority is external, then timer, then ecall. Only one trap is in flight:
 nothing issues while o_irq.pending is high, but sources keep latching.
 Software writes to mstatus update MIE only. A dispatch pulse clears the
 issued latch even if the same source fires again in that cycle.
 mret while MIE is already set is not guarded against.
*/
`timescale 1ns/10ps

module trap_controller import csr_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	// Decoded writes and enables from the register block.
	input csr_write_t i_write,
	input irq_bits_t i_enables,
	input logic [31:0] i_mtvec,

	// Interrupt sources.
	input logic i_timer_interrupt,
	input logic i_external_interrupt,
	input logic i_ecall,
	input logic i_mret,

	// Handshake with the pipeline.
	input irq_dispatch_t i_dispatch,
	output trap_state_t o_trap,
	output irq_request_t o_irq
);
	logic mstatus_mie;
	logic mstatus_mpie;
	irq_bits_t mip;
	irq_bits_t mip_next;
	irq_bits_t candidate;
	irq_bits_t select;
	irq_bits_t issued;
	logic [31:0] mcause;
	logic [31:0] select_cause;
	logic [31:0] mstatus_word;
	logic issue;

	// Next pending latches; dispatch clearing has the last word.
	always_comb begin
		mip_next = mip;
		if (i_write.mip_we)
			mip_next = irq_filter(irq_word_u'(i_write.wdata));
		if (i_external_interrupt && i_enables.external)
			mip_next.external = 1'b1;
		if (i_timer_interrupt && i_enables.timer)
			mip_next.timer = 1'b1;
		if (i_ecall && i_enables.software)
			mip_next.software = 1'b1;
		if (i_dispatch.dispatched)
			mip_next = irq_bits_t'(mip_next & ~issued);
	end

	// Highest-priority enabled source.
	always_comb begin
		candidate = irq_bits_t'(mip & i_enables);
		select = '0;
		select_cause = '0;
		if (candidate.external) begin
			select.external = 1'b1;
			select_cause = cause_external;
		end
		else if (candidate.timer) begin
			select.timer = 1'b1;
			select_cause = cause_timer;
		end
		else if (candidate.software) begin
			select.software = 1'b1;
			select_cause = cause_ecall;
		end
	end

	assign issue = mstatus_mie && !o_irq.pending && (select != '0);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mstatus_mie <= 1'b0;
			mstatus_mpie <= 1'b0;
			mip <= '0;
			issued <= '0;
			mcause <= '0;
			o_irq.pending <= 1'b0;
		end
		else begin
			mip <= mip_next;

			if (i_write.mstatus_we)
				mstatus_mie <= i_write.wdata[mstatus_mie_bit];

			// Trap entry stacks the global enable.
			if (issue) begin
				mcause <= select_cause;
				issued <= select;
				o_irq.pending <= 1'b1;
				mstatus_mpie <= mstatus_mie;
				mstatus_mie <= 1'b0;
			end

			if (i_mret) begin
				mstatus_mie <= mstatus_mpie;
				mstatus_mpie <= 1'b0;
			end

			if (i_dispatch.dispatched) begin
				o_irq.pending <= 1'b0;
				issued <= '0;
			end
		end
	end

	// Handler address, held while the request is pending.
	always_ff @(posedge i_clock) begin
		if (issue)
			o_irq.pc <= i_mtvec;
	end

	always_comb begin
		mstatus_word = '0;
		mstatus_word[mstatus_mie_bit] = mstatus_mie;
		mstatus_word[mstatus_mpie_bit] = mstatus_mpie;
	end

	assign o_trap.mstatus = mstatus_word;
	assign o_trap.mip = mip;
	assign o_trap.mcause = mcause;

endmodule

// File: hw/perf_counters.sv
/*
 Cycle, wall-time and retired-instruction counters, all 64 bits.
 The wall-time tick is one millisecond, so FREQUENCY must be a multiple
 of 1000 and at least 1000. Counters are read-only to software.
*/
`timescale 1ns/10ps

module perf_counters import csr_pkg::*; #(
	parameter int unsigned FREQUENCY = 50_000_000
)(
	input logic i_clock,
	input logic i_reset,

	// One pulse per retired instruction.
	input logic i_retire,

	output counters_t o_counters
);
	localparam int unsigned PRESCALE = FREQUENCY / 1000;
	localparam int unsigned PRESCALE_WIDTH = $clog2(PRESCALE + 1);

	logic [PRESCALE_WIDTH - 1:0] prescale;
	logic [63:0] cycle;
	logic [63:0] wtime;
	logic [63:0] instret;
	logic tick;

	// Tick on the last count of each period.
	assign tick = (prescale == PRESCALE_WIDTH'(PRESCALE - 1));

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			prescale <= '0;
			cycle <= '0;
			wtime <= '0;
			instret <= '0;
		end
		else begin
			cycle <= cycle + 64'd1;

			if (tick) begin
				prescale <= '0;
				wtime <= wtime + 64'd1;
			end
			else begin
				prescale <= prescale + 1'b1;
			end

			if (i_retire)
				instret <= instret + 64'd1;
		end
	end

	assign o_counters.cycle = cycle;
	assign o_counters.wtime = wtime;
	assign o_counters.instret = instret;

endmodule

// File: hw/machine_csr_unit.sv
/*
 Machine-mode CSR unit of a small RV32 core.
 Reads are combinational, writes take one edge. An enabled interrupt
 latches at edge N and, with MIE set, is requested after edge N+1.
 The request holds until the pipeline returns a dispatch pulse.
 FREQUENCY sets the millisecond wall-time tick.
*/
`timescale 1ns/10ps

module machine_csr_unit import csr_pkg::*; #(
	parameter int unsigned FREQUENCY = 50_000_000,
	parameter logic [31:0] VENDORID = 32'd0,
	parameter logic [31:0] ARCHID = 32'd0,
	parameter logic [31:0] IMPID = 32'd0,
	parameter logic [31:0] HARTID = 32'd0
)(
	input logic i_clock,
	input logic i_reset,

	// Instruction access.
	input csr_req_t i_csr,
	output logic [31:0] o_rdata,

	// Interrupt and trap sources.
	input logic i_timer_interrupt,
	input logic i_external_interrupt,
	input logic i_ecall,
	input logic i_mret,
	input logic i_retire,
	output logic o_external_interrupt_enable,

	// Direct reads.
	output logic [31:0] o_epc,
	output logic [31:0] o_scratch,

	// Trap handshake with the pipeline.
	output irq_request_t o_irq,
	input irq_dispatch_t i_dispatch
);
	csr_write_t csr_write;
	irq_bits_t enables;
	trap_state_t trap_state;
	counters_t counters;
	logic [31:0] mtvec;

	csr_file #(
		.VENDORID(VENDORID),
		.ARCHID(ARCHID),
		.IMPID(IMPID),
		.HARTID(HARTID)
	) u_csr_file (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_csr(i_csr),
		.o_rdata(o_rdata),
		.i_dispatch(i_dispatch),
		.i_trap(trap_state),
		.i_counters(counters),
		.o_write(csr_write),
		.o_enables(enables),
		.o_mtvec(mtvec),
		.o_epc(o_epc),
		.o_scratch(o_scratch),
		.o_external_interrupt_enable(o_external_interrupt_enable)
	);

	trap_controller u_trap_controller (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(csr_write),
		.i_enables(enables),
		.i_mtvec(mtvec),
		.i_timer_interrupt(i_timer_interrupt),
		.i_external_interrupt(i_external_interrupt),
		.i_ecall(i_ecall),
		.i_mret(i_mret),
		.i_dispatch(i_dispatch),
		.o_trap(trap_state),
		.o_irq(o_irq)
	);

	perf_counters #(
		.FREQUENCY(FREQUENCY)
	) u_perf_counters (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_retire(i_retire),
		.o_counters(counters)
	);

endmodule

// File: test/csr_tb_tasks.svh
/*
 Drive, compare and directed test tasks for the CSR unit testbench.
 Included inside tb_machine_csr_unit and uses its signals and counters.
 Every task starts and ends just after a falling clock edge.
 A CSR read takes one clock cycle of simulation time.
*/
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

task automatic compare_word(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
	checks++;
	if (actual !== expected) begin
		errors++;
		$display("Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
	end
endtask

// The handler address only matters while a request is pending.
task automatic compare_irq(input string what, input irq_request_t actual,
		input irq_request_t expected);
	checks++;
	if (actual.pending !== expected.pending ||
			(expected.pending && actual.pc !== expected.pc)) begin
		errors++;
		$display("Error at time %0t: %s is pending %b pc %h, expected pending %b pc %h",
			$time, what, actual.pending, actual.pc, expected.pending, expected.pc);
	end
endtask

task automatic write_csr(input logic [11:0] index, input logic [31:0] data);
	csr_req.index = index;
	csr_req.wdata = data;
	csr_req.write = 1'b1;
	@(negedge clock);
	csr_req.write = 1'b0;
endtask

task automatic read_csr(input logic [11:0] index, output logic [31:0] data);
	csr_req.index = index;
	csr_req.write = 1'b0;
	#10;
	data = rdata;
	@(negedge clock);
endtask

task automatic expect_csr(input logic [11:0] index, input logic [31:0] expected);
	logic [31:0] value;
	read_csr(index, value);
	compare_word($sformatf("csr %03h", index), value, expected);
endtask

task automatic wait_cycles(input int count);
	repeat (count) @(negedge clock);
endtask

task automatic pulse_sources(input logic fire_external, input logic fire_timer,
		input logic fire_ecall);
	external_interrupt = fire_external;
	timer_interrupt = fire_timer;
	ecall = fire_ecall;
	@(negedge clock);
	external_interrupt = 1'b0;
	timer_interrupt = 1'b0;
	ecall = 1'b0;
endtask

task automatic dispatch_trap(input logic [31:0] return_pc);
	dispatch.dispatched = 1'b1;
	dispatch.epc = return_pc;
	@(negedge clock);
	dispatch.dispatched = 1'b0;
endtask

task automatic return_from_trap();
	mret = 1'b1;
	@(negedge clock);
	mret = 1'b0;
endtask

task automatic verify_reset_state();
	logic [11:0] zero_index [12] = '{csr_cycle, csr_time, csr_instret, csr_cycleh,
		csr_timeh, csr_instreth, csr_mstatus, csr_mtvec, csr_mscratch, csr_mepc,
		csr_mcause, csr_mip};
	// Counters first, before the wall-time tick can move.
	foreach (zero_index[i])
		expect_csr(zero_index[i], 32'd0);
	expect_csr(csr_mie, irq_mask);
	expect_csr(csr_mvendorid, vendor_id);
	expect_csr(csr_marchid, arch_id);
	expect_csr(csr_mimpid, imp_id);
	expect_csr(csr_mhartid, hart_id);
	expect_csr(12'h7c0, 32'd0);
	compare_irq("request after reset", irq, '0);
	compare_word("external enable", {31'd0, external_enable}, 32'd1);
endtask

task automatic exercise_write_read();
	logic [31:0] value;
	logic [11:0] plain [3] = '{csr_mtvec, csr_mscratch, csr_mepc};
	foreach (plain[i]) begin
		value = $random(seed);
		write_csr(plain[i], value);
		expect_csr(plain[i], value);
		if (plain[i] == csr_mscratch)
			compare_word("o_scratch", scratch, value);
		if (plain[i] == csr_mepc)
			compare_word("o_epc", epc, value);
	end
	value = $random(seed);
	write_csr(csr_mie, value);
	expect_csr(csr_mie, value & irq_mask);
	compare_word("external enable", {31'd0, external_enable}, {31'd0, value[11]});
	write_csr(csr_mie, 32'd0);
	compare_word("external enable", {31'd0, external_enable}, 32'd0);
	write_csr(csr_mie, irq_mask);
	compare_word("external enable", {31'd0, external_enable}, 32'd1);
	// Global enable is still clear, so nothing issues.
	value = $random(seed);
	write_csr(csr_mip, value);
	expect_csr(csr_mip, value & irq_mask);
	write_csr(csr_mip, 32'd0);
	expect_csr(csr_mip, 32'd0);
endtask

task automatic run_trap_priority();
	logic [31:0] causes [3] = '{32'h8000_000b, 32'h8000_0007, 32'h0000_000b};
	logic [31:0] mip_left [3] = '{32'h0000_0088, 32'h0000_0008, 32'h0000_0000};
	logic [31:0] return_pc;
	irq_request_t expected;
	expected.pending = 1'b1;
	expected.pc = $random(seed);
	write_csr(csr_mtvec, expected.pc);
	write_csr(csr_mstatus, 32'h0000_0008);
	pulse_sources(1'b1, 1'b1, 1'b1);
	foreach (causes[i]) begin
		// Issue edge follows the latch edge or the mret edge.
		@(negedge clock);
		compare_irq("trap request", irq, expected);
		expect_csr(csr_mcause, causes[i]);
		expect_csr(csr_mstatus, 32'h0000_0080);
		return_pc = $random(seed);
		dispatch_trap(return_pc);
		compare_irq("request after dispatch", irq, '0);
		expect_csr(csr_mepc, return_pc);
		compare_word("o_epc", epc, return_pc);
		expect_csr(csr_mip, mip_left[i]);
		return_from_trap();
	end
	expect_csr(csr_mstatus, 32'h0000_0008);
endtask

task automatic check_masking();
	irq_request_t expected;
	write_csr(csr_mie, 32'h0000_0808);
	pulse_sources(1'b0, 1'b1, 1'b0);
	wait_cycles(2);
	compare_irq("masked timer", irq, '0);
	expect_csr(csr_mip, 32'd0);
	write_csr(csr_mstatus, 32'd0);
	pulse_sources(1'b1, 1'b0, 1'b0);
	wait_cycles(2);
	compare_irq("held external", irq, '0);
	expect_csr(csr_mip, 32'h0000_0800);
	expected.pending = 1'b1;
	expected.pc = $random(seed);
	write_csr(csr_mtvec, expected.pc);
	write_csr(csr_mstatus, 32'h0000_0008);
	@(negedge clock);
	compare_irq("late external", irq, expected);
	expect_csr(csr_mcause, 32'h8000_000b);
	dispatch_trap($random(seed));
	return_from_trap();
	expect_csr(csr_mip, 32'd0);
	write_csr(csr_mie, irq_mask);
endtask

task automatic measure_counters();
	logic [31:0] first;
	logic [31:0] second;
	int gap;
	int pulses;
	int ticks;
	int advance;
	read_csr(csr_cycle, first);
	gap = 5 + ($unsigned($random(seed)) % 16);
	wait_cycles(gap);
	read_csr(csr_cycle, second);
	compare_word("cycle difference", second - first, gap + 1);
	// Eight cycles per tick at this clock rate.
	ticks = 6;
	read_csr(csr_time, first);
	wait_cycles(8 * ticks - 1);
	read_csr(csr_time, second);
	advance = second - first;
	checks++;
	if (advance < ticks - 1 || advance > ticks + 1) begin
		errors++;
		$display("Error at time %0t: time advanced by %0d, expected %0d +-1",
			$time, advance, ticks);
	end
	read_csr(csr_instret, first);
	pulses = 8 + ($unsigned($random(seed)) % 5);
	repeat (pulses) begin
		retire = 1'b1;
		@(negedge clock);
		retire = 1'b0;
		wait_cycles($unsigned($random(seed)) % 3);
	end
	read_csr(csr_instret, second);
	compare_word("retired instructions", second - first, pulses);
	expect_csr(csr_instreth, 32'd0);
	expect_csr(csr_cycleh, 32'd0);
endtask

`endif

// File: test/tb_machine_csr_unit.sv
/*
 Directed testbench for the machine CSR unit.
 FREQUENCY is 8000, so one wall-time tick takes 8 clock cycles.
 Inputs change on falling edges and outputs are sampled in the low phase.
 A watchdog bounds the run.
*/
`timescale 1ns/10ps

module tb_machine_csr_unit import csr_pkg::*; ();
	localparam int clock_period = 100;
	localparam logic [31:0] vendor_id = 32'h0000_0a5a;
	localparam logic [31:0] arch_id = 32'h0000_0023;
	localparam logic [31:0] imp_id = 32'h0001_0004;
	localparam logic [31:0] hart_id = 32'h0000_0002;

	// Interrupt bits 11, 7 and 3.
	localparam logic [31:0] irq_mask = 32'h0000_0888;

	// Reset, the five tests and a margin, in cycles.
	localparam int run_cycles = 4 + 20 + 25 + 40 + 35 + 120 + 100;

	logic clock;
	logic reset;
	csr_req_t csr_req;
	logic timer_interrupt;
	logic external_interrupt;
	logic ecall;
	logic mret;
	logic retire;
	irq_dispatch_t dispatch;
	logic [31:0] rdata;
	logic [31:0] epc;
	logic [31:0] scratch;
	logic external_enable;
	irq_request_t irq;

	int errors;
	int checks;
	integer seed;

	`include "csr_tb_tasks.svh"

	machine_csr_unit #(
		.FREQUENCY(8000),
		.VENDORID(vendor_id),
		.ARCHID(arch_id),
		.IMPID(imp_id),
		.HARTID(hart_id)
	) DUT (
		.i_clock(clock),
		.i_reset(reset),
		.i_csr(csr_req),
		.o_rdata(rdata),
		.i_timer_interrupt(timer_interrupt),
		.i_external_interrupt(external_interrupt),
		.i_ecall(ecall),
		.i_mret(mret),
		.i_retire(retire),
		.o_external_interrupt_enable(external_enable),
		.o_epc(epc),
		.o_scratch(scratch),
		.o_irq(irq),
		.i_dispatch(dispatch)
	);

	always #(clock_period / 2) clock = ~clock;

	initial begin
		#(run_cycles * clock_period);
		$display("Timeout: the tests were still running after %0d cycles", run_cycles);
		$display("test failed");
		$finish;
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		csr_req = '0;
		timer_interrupt = 1'b0;
		external_interrupt = 1'b0;
		ecall = 1'b0;
		mret = 1'b0;
		retire = 1'b0;
		dispatch = '0;
		errors = 0;
		checks = 0;
		seed = 32'h5896_92e7;
		repeat (4) @(negedge clock);
		reset = 1'b0;

		verify_reset_state();
		exercise_write_read();
		run_trap_priority();
		check_masking();
		measure_counters();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: machine_csr_unit.f
+incdir+test
hw/csr_pkg.sv
hw/csr_file.sv
hw/trap_controller.sv
hw/perf_counters.sv
hw/machine_csr_unit.sv
test/tb_machine_csr_unit.sv
